// ==== flist.f ====
+incdir+include
hdl/glue_pkg.sv
hdl/io_decoder.sv
hdl/ems_mapper.sv
hdl/lpt_port.sv
hdl/read_mux.sv
hdl/peripheral_glue.sv
test/peripheral_glue_asserts.sv
test/peripheral_glue_tb.sv

// ==== hdl/ems_mapper.sv ====
//**************************************************************************
// EMS page mapper: four page registers behind ports 0x260-0x263, a
// two-stage write path and the bank hits of the selected window
//**************************************************************************

`timescale 1ns/1ps

`include "glue_macros.svh"

module ems_mapper (
    input  logic                          clock,
    input  logic                          reset,
    input  glue_pkg::bus_req_t            bus_i,
    input  logic                          ems_port_hit_i,
    input  logic [1:0]                    ems_window_i,
    output glue_pkg::ems_map_t            ems_map_o,
    output logic [`EMS_WINDOWS-1:0]       ems_bank_o
);

    localparam int IDX_W = $clog2(`EMS_WINDOWS);

    glue_pkg::ems_cmd_e    wr_cmd;
    glue_pkg::ems_cmd_e    wr_cmd_q;
    logic                  wr_valid_q;
    logic [`EMS_PAGE_W-1:0] wr_page_q;
    logic [IDX_W-1:0]      wr_index_q;
    glue_pkg::ems_map_t    map_q;
    logic                  mem_cycle;
    logic [3:0]            window_base;

    // Classify the written value
    always_comb begin
        if (bus_i.data == `EMS_UNMAP_CODE) begin
            wr_cmd = glue_pkg::EMS_UNMAP;
        end else if (bus_i.data < `EMS_MAP_LIMIT) begin
            wr_cmd = glue_pkg::EMS_MAP;
        end else begin
            wr_cmd = glue_pkg::EMS_KEEP;
        end
    end

    // Stage 1: capture the write
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            wr_valid_q <= 1'b0;
            wr_cmd_q   <= glue_pkg::EMS_KEEP;
        end else begin
            wr_valid_q <= ems_port_hit_i & ~bus_i.io_write_n;
            wr_cmd_q   <= wr_cmd;
        end
    end

    always_ff @(posedge clock) begin
        wr_page_q  <= bus_i.data[`EMS_PAGE_W-1:0];
        wr_index_q <= bus_i.address[IDX_W-1:0];
    end

    // Stage 2: update the entry
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            map_q <= '0;
        end else if (wr_valid_q) begin
            case (wr_cmd_q)
                glue_pkg::EMS_UNMAP: begin
                    map_q.page[wr_index_q]   <= `EMS_PAGE_W'(`EMS_UNMAP_CODE);
                    map_q.enable[wr_index_q] <= 1'b0;
                end
                glue_pkg::EMS_MAP: begin
                    map_q.page[wr_index_q]   <= wr_page_q;
                    map_q.enable[wr_index_q] <= 1'b1;
                end
                default: begin
                end
            endcase
        end
    end

    assign ems_map_o = map_q;

    // Window at A0000, C0000 or D0000
    always_comb begin
        case (ems_window_i)
            2'd0:    window_base = 4'hA;
            2'd1:    window_base = 4'hC;
            default: window_base = 4'hD;
        endcase
    end

    assign mem_cycle = bus_i.io_read_n & bus_i.io_write_n;

    // 16 KB slice per bank
    always_comb begin
        for (int k = 0; k < `EMS_WINDOWS; k++) begin
            ems_bank_o[k] = mem_cycle && map_q.enable[k] &&
                            (bus_i.address[19:14] == {window_base, IDX_W'(k)});
        end
    end

endmodule

// ==== hdl/glue_pkg.sv ====
//**************************************************************************
// Shared types of the bus glue: CPU cycle, chip selects, device hits,
// external read data, EMS map, EMS command and read source
//**************************************************************************

`include "glue_macros.svh"

package glue_pkg;

    // One CPU bus cycle as seen by the glue
    typedef struct packed {
        logic [`GLUE_ADDR_W-1:0] address;
        logic [`GLUE_DATA_W-1:0] data;
        logic                    io_read_n;
        logic                    io_write_n;
        logic                    memory_read_n;
        logic                    memory_write_n;
        logic                    address_enable_n;
        logic                    interrupt_acknowledge_n;
    } bus_req_t;

    // Active low selects to the external chips
    typedef struct packed {
        logic dma_n;
        logic pic_n;
        logic pit_n;
        logic ppi_n;
        logic dma_page_n;
        logic uart_n;
        logic bios_n;
    } chip_sel_t;

    // Ports that live inside the glue
    typedef struct packed {
        logic ems_port;
        logic lpt_data;
        logic lpt_stat;
    } dev_hit_t;

    typedef struct packed {
        logic [`GLUE_DATA_W-1:0] pic;
        logic [`GLUE_DATA_W-1:0] pit;
        logic [`GLUE_DATA_W-1:0] ppi;
        logic [`GLUE_DATA_W-1:0] uart;
        logic [`GLUE_DATA_W-1:0] bios;
    } ext_rd_t;

    typedef struct packed {
        logic [`EMS_WINDOWS-1:0][`EMS_PAGE_W-1:0] page;
        logic [`EMS_WINDOWS-1:0]                  enable;
    } ems_map_t;

    typedef enum logic [1:0] {
        EMS_UNMAP,
        EMS_MAP,
        EMS_KEEP
    } ems_cmd_e;

    typedef enum logic [3:0] {
        RD_NONE,
        RD_PIC,
        RD_PIT,
        RD_PPI,
        RD_BIOS,
        RD_UART,
        RD_EMS,
        RD_LPT_DATA,
        RD_LPT_STAT
    } rd_src_e;

endpackage

// ==== hdl/io_decoder.sv ====
//**************************************************************************
// I/O and memory cycle decoder: external chip selects and the hits for
// the EMS mapper and printer port
//**************************************************************************

`timescale 1ns/1ps

`include "glue_macros.svh"

module io_decoder (
    input  glue_pkg::bus_req_t  bus_i,
    input  logic                ems_enabled_i,
    output glue_pkg::chip_sel_t cs_o,
    output glue_pkg::dev_hit_t  hit_o
);

    logic        io_cycle;
    logic        io_addressed;
    logic        mem_addressed;
    logic        sys_io;
    logic [15:0] port;
    logic [4:0]  block_sel;

    assign io_cycle      = ~bus_i.io_read_n | ~bus_i.io_write_n;
    assign io_addressed  = io_cycle & ~bus_i.address_enable_n;
    assign mem_addressed = ~io_cycle & ~bus_i.address_enable_n;
    assign port          = bus_i.address[15:0];

    // System board ports 0x000-0x0FF
    assign sys_io = io_addressed && (bus_i.address[9:8] == 2'b00);

    // One hit per 32-port block
    always_comb begin
        block_sel = '0;
        for (int k = 0; k < 5; k++) begin
            block_sel[k] = sys_io && (bus_i.address[7:5] == 3'(k));
        end
    end

    always_comb begin
        cs_o.dma_n      = ~block_sel[0];
        cs_o.pic_n      = ~block_sel[1];
        cs_o.pit_n      = ~block_sel[2];
        cs_o.ppi_n      = ~block_sel[3];
        cs_o.dma_page_n = ~block_sel[4];

        // 0x3F8-0x3FF
        cs_o.uart_n = ~(~bus_i.address_enable_n &&
                        (port[15:3] == 13'(`UART_PORT_BASE >> 3)));

        // F0000-FFFFF
        cs_o.bios_n = ~(mem_addressed && (bus_i.address[19:16] == 4'hF));
    end

    always_comb begin
        // 0x260-0x263
        hit_o.ems_port = io_addressed && ems_enabled_i &&
                         (port[15:2] == 14'(`EMS_PORT_BASE >> 2));
        hit_o.lpt_data = io_addressed && (port == `LPT_DATA_PORT);
        hit_o.lpt_stat = io_addressed && (port == `LPT_STAT_PORT);
    end

endmodule

// ==== hdl/lpt_port.sv ====
//**************************************************************************
// Printer port: data latch at 0x378 and status byte at 0x379
//**************************************************************************

`timescale 1ns/1ps

`include "glue_macros.svh"

module lpt_port (
    input  logic                    clock,
    input  logic                    reset,
    input  glue_pkg::bus_req_t      bus_i,
    input  logic                    lpt_data_hit_i,
    input  logic                    dss_full_i,
    output logic [`GLUE_DATA_W-1:0] lpt_data_o,
    output logic [`GLUE_DATA_W-1:0] lpt_stat_o
);

    logic [`GLUE_DATA_W-1:0] data_q;

    // Idle printer bus reads all ones
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            data_q <= '1;
        end else if (lpt_data_hit_i && !bus_i.io_write_n) begin
            data_q <= bus_i.data;
        end
    end

    assign lpt_data_o = data_q;

    // Sound FIFO full in bit 6
    always_comb begin
        lpt_stat_o    = '0;
        lpt_stat_o[6] = dss_full_i;
    end

endmodule

// ==== hdl/peripheral_glue.sv ====
//**************************************************************************
// Peripheral bus glue top level: decoder, EMS mapper, printer port and
// the CPU read mux
//**************************************************************************

`timescale 1ns/1ps

`include "glue_macros.svh"

module peripheral_glue (
    input  logic                    clock,
    input  logic                    reset,
    input  glue_pkg::bus_req_t      bus_i,
    input  logic                    ems_enabled_i,
    input  logic [1:0]              ems_window_i,
    input  logic                    dss_full_i,
    input  glue_pkg::ext_rd_t       ext_rd_i,
    output glue_pkg::chip_sel_t     cs_o,
    output glue_pkg::ems_map_t      ems_map_o,
    output logic [`EMS_WINDOWS-1:0] ems_bank_o,
    output logic [`GLUE_DATA_W-1:0] data_bus_out_o,
    output logic                    data_bus_out_from_chipset_o
);

    glue_pkg::chip_sel_t     cs;
    glue_pkg::dev_hit_t      hit;
    glue_pkg::ems_map_t      ems_map;
    logic [`GLUE_DATA_W-1:0] lpt_data;
    logic [`GLUE_DATA_W-1:0] lpt_stat;

    assign cs_o      = cs;
    assign ems_map_o = ems_map;

    io_decoder u_io_decoder (
        .bus_i         (bus_i),
        .ems_enabled_i (ems_enabled_i),
        .cs_o          (cs),
        .hit_o         (hit)
    );

    ems_mapper u_ems_mapper (
        .clock          (clock),
        .reset          (reset),
        .bus_i          (bus_i),
        .ems_port_hit_i (hit.ems_port),
        .ems_window_i   (ems_window_i),
        .ems_map_o      (ems_map),
        .ems_bank_o     (ems_bank_o)
    );

    lpt_port u_lpt_port (
        .clock          (clock),
        .reset          (reset),
        .bus_i          (bus_i),
        .lpt_data_hit_i (hit.lpt_data),
        .dss_full_i     (dss_full_i),
        .lpt_data_o     (lpt_data),
        .lpt_stat_o     (lpt_stat)
    );

    // Combinational path from bus to data out
    read_mux u_read_mux (
        .bus_i                       (bus_i),
        .cs_i                        (cs),
        .hit_i                       (hit),
        .ext_rd_i                    (ext_rd_i),
        .ems_map_i                   (ems_map),
        .lpt_data_i                  (lpt_data),
        .lpt_stat_i                  (lpt_stat),
        .data_bus_out_o              (data_bus_out_o),
        .data_bus_out_from_chipset_o (data_bus_out_from_chipset_o)
    );

endmodule

// ==== hdl/read_mux.sv ====
//**************************************************************************
// CPU read data: prioritized source selection and the drive flag
//**************************************************************************

`timescale 1ns/1ps

`include "glue_macros.svh"

module read_mux (
    input  glue_pkg::bus_req_t      bus_i,
    input  glue_pkg::chip_sel_t     cs_i,
    input  glue_pkg::dev_hit_t      hit_i,
    input  glue_pkg::ext_rd_t       ext_rd_i,
    input  glue_pkg::ems_map_t      ems_map_i,
    input  logic [`GLUE_DATA_W-1:0] lpt_data_i,
    input  logic [`GLUE_DATA_W-1:0] lpt_stat_i,
    output logic [`GLUE_DATA_W-1:0] data_bus_out_o,
    output logic                    data_bus_out_from_chipset_o
);

    glue_pkg::rd_src_e       rd_src;
    logic                    io_rd;
    logic                    mem_rd;
    logic [1:0]              ems_index;
    logic [`GLUE_DATA_W-1:0] ems_rd;

    assign io_rd     = ~bus_i.io_read_n;
    assign mem_rd    = ~bus_i.memory_read_n;
    assign ems_index = bus_i.address[1:0];

    // Unmapped entries read back as all ones
    assign ems_rd = ems_map_i.enable[ems_index] ?
                    `GLUE_DATA_W'(ems_map_i.page[ems_index]) : `EMS_UNMAP_CODE;

    always_comb begin
        if (!bus_i.interrupt_acknowledge_n) begin
            rd_src = glue_pkg::RD_PIC;
        end else if (!cs_i.pic_n && io_rd) begin
            rd_src = glue_pkg::RD_PIC;
        end else if (!cs_i.pit_n && io_rd) begin
            rd_src = glue_pkg::RD_PIT;
        end else if (!cs_i.ppi_n && io_rd) begin
            rd_src = glue_pkg::RD_PPI;
        end else if (!cs_i.bios_n && mem_rd) begin
            rd_src = glue_pkg::RD_BIOS;
        end else if (!cs_i.uart_n && io_rd) begin
            rd_src = glue_pkg::RD_UART;
        end else if (hit_i.ems_port && io_rd) begin
            rd_src = glue_pkg::RD_EMS;
        end else if (hit_i.lpt_data && io_rd) begin
            rd_src = glue_pkg::RD_LPT_DATA;
        end else if (hit_i.lpt_stat && io_rd) begin
            rd_src = glue_pkg::RD_LPT_STAT;
        end else begin
            rd_src = glue_pkg::RD_NONE;
        end
    end

    always_comb begin
        case (rd_src)
            glue_pkg::RD_PIC:      data_bus_out_o = ext_rd_i.pic;
            glue_pkg::RD_PIT:      data_bus_out_o = ext_rd_i.pit;
            glue_pkg::RD_PPI:      data_bus_out_o = ext_rd_i.ppi;
            glue_pkg::RD_BIOS:     data_bus_out_o = ext_rd_i.bios;
            glue_pkg::RD_UART:     data_bus_out_o = ext_rd_i.uart;
            glue_pkg::RD_EMS:      data_bus_out_o = ems_rd;
            glue_pkg::RD_LPT_DATA: data_bus_out_o = lpt_data_i;
            glue_pkg::RD_LPT_STAT: data_bus_out_o = lpt_stat_i;
            default:               data_bus_out_o = '0;
        endcase
    end

    assign data_bus_out_from_chipset_o = (rd_src != glue_pkg::RD_NONE);

endmodule

// ==== include/glue_macros.svh ====
//**************************************************************************
// Bus glue constants: bus widths, I/O port addresses of the EMS mapper,
// printer port and UART, and the EMS page register encoding
//**************************************************************************

`ifndef GLUE_MACROS_SVH
`define GLUE_MACROS_SVH

// Bus widths
`define GLUE_ADDR_W     20
`define GLUE_DATA_W     8

// I/O port addresses
`define EMS_PORT_BASE   16'h0260
`define LPT_DATA_PORT   16'h0378
`define LPT_STAT_PORT   16'h0379
`define UART_PORT_BASE  16'h03F8

// EMS page mapper
`define EMS_PAGE_W      7
`define EMS_WINDOWS     4

// Write data codes for the page registers
`define EMS_UNMAP_CODE  8'hFF
`define EMS_MAP_LIMIT   8'h80

`endif

// ==== test/peripheral_glue_asserts.sv ====
//**************************************************************************
// Bound checker for the bus glue: reference model of the decode, EMS map,
// printer latch and read priority, concurrent assertions, error counter
//**************************************************************************

`timescale 1ns/1ps

`include "glue_macros.svh"

module peripheral_glue_asserts (
    input logic                    clock,
    input logic                    reset,
    input glue_pkg::bus_req_t      bus_i,
    input logic                    ems_enabled_i,
    input logic [1:0]              ems_window_i,
    input logic                    dss_full_i,
    input glue_pkg::ext_rd_t       ext_rd_i,
    input glue_pkg::chip_sel_t     cs_o,
    input glue_pkg::ems_map_t      ems_map_o,
    input logic [`EMS_WINDOWS-1:0] ems_bank_o,
    input logic [`GLUE_DATA_W-1:0] data_bus_out_o,
    input logic                    data_bus_out_from_chipset_o
);

    int                                       errors = 0;
    logic [`EMS_WINDOWS-1:0][`EMS_PAGE_W-1:0] page;
    logic [`EMS_WINDOWS-1:0]                  en;
    logic                                     wr_pend;
    logic [7:0]                               wr_data;
    logic [1:0]                               wr_idx;
    logic [7:0]                               lpt_latch;
    logic                                     io;
    logic                                     ems_hit;
    logic                                     lpt_hit;
    logic                                     stat_hit;
    logic [3:0]                               base;
    glue_pkg::chip_sel_t                      exp_cs;
    logic [7:0]                               exp_data;
    logic                                     exp_flag;
    logic [`EMS_WINDOWS-1:0]                  exp_bank;

    // Shadow of the page entries, applied one edge after the write is seen
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            wr_pend   <= 1'b0;
            wr_data   <= '0;
            wr_idx    <= '0;
            page      <= '0;
            en        <= '0;
            lpt_latch <= 8'hFF;
        end else begin
            wr_pend <= ems_hit && !bus_i.io_write_n;
            wr_data <= bus_i.data;
            wr_idx  <= bus_i.address[1:0];
            if (lpt_hit && !bus_i.io_write_n) begin
                lpt_latch <= bus_i.data;
            end
            if (wr_pend && wr_data == 8'hFF) begin
                en[wr_idx]   <= 1'b0;
                page[wr_idx] <= 7'h7F;
            end else if (wr_pend && wr_data < 8'h80) begin
                en[wr_idx]   <= 1'b1;
                page[wr_idx] <= wr_data[6:0];
            end
        end
    end

    always_comb begin
        io       = !bus_i.io_read_n || !bus_i.io_write_n;
        ems_hit  = io && !bus_i.address_enable_n && ems_enabled_i &&
                   ({bus_i.address[15:2], 2'b00} == `EMS_PORT_BASE);
        lpt_hit  = io && !bus_i.address_enable_n && (bus_i.address[15:0] == `LPT_DATA_PORT);
        stat_hit = io && !bus_i.address_enable_n && (bus_i.address[15:0] == `LPT_STAT_PORT);
        exp_cs   = '1;
        if (!bus_i.address_enable_n && io && bus_i.address[9:8] == 2'b00) begin
            case (bus_i.address[7:5])
                3'd0: exp_cs.dma_n = 1'b0;
                3'd1: exp_cs.pic_n = 1'b0;
                3'd2: exp_cs.pit_n = 1'b0;
                3'd3: exp_cs.ppi_n = 1'b0;
                3'd4: exp_cs.dma_page_n = 1'b0;
                default: ;
            endcase
        end
        exp_cs.uart_n = !(!bus_i.address_enable_n &&
                          ({bus_i.address[15:3], 3'b000} == `UART_PORT_BASE));
        exp_cs.bios_n = !(!bus_i.address_enable_n && !io && bus_i.address[19:16] == 4'hF);
        exp_flag = 1'b1;
        if (!bus_i.interrupt_acknowledge_n) begin
            exp_data = ext_rd_i.pic;
        end else if (!bus_i.io_read_n && !exp_cs.pic_n) begin
            exp_data = ext_rd_i.pic;
        end else if (!bus_i.io_read_n && !exp_cs.pit_n) begin
            exp_data = ext_rd_i.pit;
        end else if (!bus_i.io_read_n && !exp_cs.ppi_n) begin
            exp_data = ext_rd_i.ppi;
        end else if (!bus_i.memory_read_n && !exp_cs.bios_n) begin
            exp_data = ext_rd_i.bios;
        end else if (!bus_i.io_read_n && !exp_cs.uart_n) begin
            exp_data = ext_rd_i.uart;
        end else if (!bus_i.io_read_n && ems_hit) begin
            exp_data = en[bus_i.address[1:0]] ? {1'b0, page[bus_i.address[1:0]]} : 8'hFF;
        end else if (!bus_i.io_read_n && lpt_hit) begin
            exp_data = lpt_latch;
        end else if (!bus_i.io_read_n && stat_hit) begin
            exp_data = {1'b0, dss_full_i, 6'b000000};
        end else begin
            exp_data = '0;
            exp_flag = 1'b0;
        end
        // Window at A0000, C0000 or D0000
        base = (ems_window_i == 2'd0) ? 4'hA : (ems_window_i == 2'd1) ? 4'hC : 4'hD;
        for (int k = 0; k < `EMS_WINDOWS; k++) begin
            exp_bank[k] = !io && en[k] && (bus_i.address[19:14] == {base, 2'(k)});
        end
    end

    assert property (@(posedge clock) disable iff (reset) cs_o == exp_cs)
        else begin
            errors++;
            $error("mismatch at %0t: cs_o %b expected %b", $time, $sampled(cs_o),
                   $sampled(exp_cs));
        end

    assert property (@(posedge clock) disable iff (reset) data_bus_out_o == exp_data)
        else begin
            errors++;
            $error("mismatch at %0t: data_bus_out_o %h expected %h", $time,
                   $sampled(data_bus_out_o), $sampled(exp_data));
        end

    assert property (@(posedge clock) disable iff (reset)
                     data_bus_out_from_chipset_o == exp_flag)
        else begin
            errors++;
            $error("mismatch at %0t: data_bus_out_from_chipset_o %b expected %b", $time,
                   $sampled(data_bus_out_from_chipset_o), $sampled(exp_flag));
        end

    assert property (@(posedge clock) disable iff (reset) ems_bank_o == exp_bank)
        else begin
            errors++;
            $error("mismatch at %0t: ems_bank_o %b expected %b", $time,
                   $sampled(ems_bank_o), $sampled(exp_bank));
        end

    assert property (@(posedge clock) disable iff (reset)
                     ems_map_o.page == page && ems_map_o.enable == en)
        else begin
            errors++;
            $error("mismatch at %0t: ems_map_o %h expected %h", $time,
                   $sampled(ems_map_o), {$sampled(page), $sampled(en)});
        end

endmodule

bind peripheral_glue peripheral_glue_asserts u_asserts (.*);

// ==== test/peripheral_glue_tb.sv ====
//**************************************************************************
// Testbench for the peripheral bus glue: clock, reset, bus stimulus,
// timeout and the closing report
//**************************************************************************

`timescale 1ns/1ps

`include "glue_macros.svh"

module peripheral_glue_tb;

    localparam int MAX_CYCLES = 400;

    logic                    clock;
    logic                    reset;
    glue_pkg::bus_req_t      bus;
    logic                    ems_enabled;
    logic [1:0]              ems_window;
    logic                    dss_full;
    glue_pkg::ext_rd_t       ext_rd;
    glue_pkg::chip_sel_t     cs;
    glue_pkg::ems_map_t      ems_map;
    logic [`EMS_WINDOWS-1:0] ems_bank;
    logic [`GLUE_DATA_W-1:0] data_out;
    logic                    data_drive;
    integer                  seed = 32'h8fc61019;
    int                      cycles = 0;
    int                      timeouts = 0;

    peripheral_glue dut_i (
        .clock                       (clock),
        .reset                       (reset),
        .bus_i                       (bus),
        .ems_enabled_i               (ems_enabled),
        .ems_window_i                (ems_window),
        .dss_full_i                  (dss_full),
        .ext_rd_i                    (ext_rd),
        .cs_o                        (cs),
        .ems_map_o                   (ems_map),
        .ems_bank_o                  (ems_bank),
        .data_bus_out_o              (data_out),
        .data_bus_out_from_chipset_o (data_drive)
    );

    always #10 clock = ~clock;

    // No strobes, CPU owns the bus
    function automatic glue_pkg::bus_req_t rest_cycle();
        glue_pkg::bus_req_t c;
        c = '0;
        c.io_read_n = 1'b1;
        c.io_write_n = 1'b1;
        c.memory_read_n = 1'b1;
        c.memory_write_n = 1'b1;
        c.interrupt_acknowledge_n = 1'b1;
        return c;
    endfunction

    // Mostly maps, sometimes unmaps or keeps
    function automatic logic [7:0] ems_write_data();
        logic [7:0] r;
        r = 8'($random(seed));
        case (r[1:0])
            2'd0:    return 8'hFF;
            2'd1:    return 8'h80 | r;
            default: return r & 8'h7F;
        endcase
    endfunction

    task automatic drive(input glue_pkg::bus_req_t c);
        @(posedge clock);
        bus    <= c;
        ext_rd <= 40'({$random(seed), $random(seed)});
    endtask

    task automatic io_read(input logic [19:0] addr, input logic aen_n);
        glue_pkg::bus_req_t c;
        c = rest_cycle();
        c.address = addr;
        c.io_read_n = 1'b0;
        c.address_enable_n = aen_n;
        drive(c);
    endtask

    task automatic io_write(input logic [19:0] addr, input logic [7:0] data);
        glue_pkg::bus_req_t c;
        c = rest_cycle();
        c.address = addr;
        c.data = data;
        c.io_write_n = 1'b0;
        drive(c);
    endtask

    task automatic mem_read(input logic [19:0] addr);
        glue_pkg::bus_req_t c;
        c = rest_cycle();
        c.address = addr;
        c.memory_read_n = 1'b0;
        drive(c);
    endtask

    task automatic int_ack();
        glue_pkg::bus_req_t c;
        c = rest_cycle();
        c.interrupt_acknowledge_n = 1'b0;
        drive(c);
    endtask

    task automatic finish_run();
        $display("Assertion errors: %0d, timeouts: %0d", dut_i.u_asserts.errors, timeouts);
        if (dut_i.u_asserts.errors == 0 && timeouts == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    endtask

    always @(posedge clock) begin
        cycles++;
        if (cycles == MAX_CYCLES) begin
            timeouts++;
            $display("Timeout: stimulus still running after %0d cycles", MAX_CYCLES);
            finish_run();
        end
    end

    initial begin
        logic [1:0]  idx;
        logic [19:0] addr;
        clock = 1'b0;
        reset = 1'b1;
        bus = rest_cycle();
        ems_enabled = 1'b0;
        ems_window = 2'd0;
        dss_full = 1'b0;
        ext_rd = '0;
        repeat (10) @(posedge clock);
        reset <= 1'b0;
        drive(rest_cycle());
        drive(rest_cycle());
        // Chip selects, then the same ports with AEN high
        for (int p = 0; p < 'hA0; p += 8) begin
            io_read(20'(p + ($random(seed) & 7)), 1'b0);
        end
        repeat (4) io_read(20'($random(seed)) & 20'h0009F, 1'b1);
        for (int p = 0; p < 8; p++) begin
            io_read(20'h003F8 + 20'(p), 1'b0);
        end
        repeat (4) mem_read(20'hF0000 | (20'($random(seed)) & 20'h0FFFF));
        int_ack();
        int_ack();
        // Printer port
        io_read(20'h00378, 1'b0);
        io_read(20'h00379, 1'b0);
        drive(rest_cycle());
        dss_full <= 1'b1;
        io_read(20'h00379, 1'b0);
        io_write(20'h00378, 8'($random(seed)));
        io_read(20'h00378, 1'b0);
        // EMS writes, back to back, each followed by a full readback
        ems_enabled <= 1'b1;
        repeat (16) begin
            idx = 2'($random(seed));
            io_write(20'h00260 + 20'(idx), ems_write_data());
            io_write(20'h00260 + 20'(2'(idx + 2'd1)), ems_write_data());
            for (int k = 0; k < 4; k++) begin
                io_read(20'h00260 + 20'(k), 1'b0);
            end
        end
        // A write with the mapper disabled must not land
        io_write(20'h00260, 8'hFF);
        drive(rest_cycle());
        ems_enabled <= 1'b0;
        io_write(20'h00260, 8'h05);
        drive(rest_cycle());
        ems_enabled <= 1'b1;
        io_read(20'h00260, 1'b0);
        // Map all four entries, then unmap one per window
        for (int k = 0; k < 4; k++) begin
            io_write(20'h00260 + 20'(k), 8'(k + 'h10));
        end
        // Bank hits, about half the addresses inside the selected window
        for (int w = 0; w < 4; w++) begin
            ems_window <= 2'(w);
            io_write(20'h00260 + 20'(w), 8'hFF);
            repeat (10) begin
                addr = 20'($random(seed));
                if (addr[0]) begin
                    addr[19:16] = (w == 0) ? 4'hA : (w == 1) ? 4'hC : 4'hD;
                end
                mem_read(addr);
            end
            io_write(20'h00260 + 20'(w), 8'(w + 'h10));
        end
        drive(rest_cycle());
        drive(rest_cycle());
        finish_run();
    end

endmodule
